/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_openram_testchip
FILELIST := src.f
PASS_MSG := Regression passed

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* include/openram_config.svh */
`ifndef OPENRAM_CONFIG_SVH
`define OPENRAM_CONFIG_SVH

// data word of one macro port
`define OPENRAM_DATA_SIZE 32

// widest address over all macros
`define OPENRAM_ADDR_SIZE 16

// one mask bit per data byte
`define OPENRAM_WMASK_SIZE 4

// chip-select field at the top of the test word
`define OPENRAM_SELECT_SIZE 4

// macros hanging off the shared port buses
`define OPENRAM_MAX_CHIPS 16

`endif

/* source/openram_port_pkg.sv */
`default_nettype none

`include "openram_config.svh"

package openram_port_pkg;

	// values seen on the shared sram port buses
	typedef logic [`OPENRAM_ADDR_SIZE-1:0] sram_addr_t;
	typedef logic [`OPENRAM_DATA_SIZE-1:0] sram_data_t;
	typedef logic [`OPENRAM_WMASK_SIZE-1:0] sram_wmask_t; // byte write mask

	// index of the macro under test
	typedef logic [`OPENRAM_SELECT_SIZE-1:0] chip_sel_t;

	// one active-low select per macro, bit k goes to macro k
	typedef logic [`OPENRAM_MAX_CHIPS-1:0] csb_vec_t;

endpackage

`default_nettype wire

/* source/openram_testchip.sv */
`timescale 1ns/1ps
`default_nettype none

`include "openram_config.svh"

module openram_testchip
	import openram_port_pkg::*, openram_word_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,

	// test controls
	input wire logic gpio_i,
	input wire logic gpio_scan_i,
	input wire logic gpio_sram_load_i,
	input wire logic la_in_load_i,
	input wire logic [TEST_WORD_BITS-1:0] la_data_i,
	input wire logic la_sram_load_i,
	input wire logic global_csb_i,

	// read data coming back from the macros
	input wire sram_data_t sram_rdata0_i [`OPENRAM_MAX_CHIPS],
	input wire sram_data_t sram_rdata1_i [`OPENRAM_MAX_CHIPS],

	// word readout
	output wire logic [TEST_WORD_BITS-1:0] la_data_o,
	output wire logic gpio_o,

	output wire sram_addr_t addr0_o,
	output wire sram_data_t din0_o,
	output wire logic web0_o,
	output wire sram_wmask_t wmask0_o,
	output wire csb_vec_t csb0_o,

	output wire sram_addr_t addr1_o,
	output wire sram_data_t din1_o,
	output wire logic web1_o,
	output wire sram_wmask_t wmask1_o,
	output wire csb_vec_t csb1_o
);

	test_word_u test_word;

	test_word_register u_word (
		.clk(clk),
		.resetn(resetn),
		.gpio_i(gpio_i),
		.gpio_scan_i(gpio_scan_i),
		.gpio_sram_load_i(gpio_sram_load_i),
		.la_in_load_i(la_in_load_i),
		.la_data_i(la_data_i),
		.la_sram_load_i(la_sram_load_i),
		.sram_rdata0_i(sram_rdata0_i),
		.sram_rdata1_i(sram_rdata1_i),
		.test_word_o(test_word),
		.la_data_o(la_data_o),
		.gpio_o(gpio_o)
	);

	// port buses follow the word with no extra register stage
	sram_port_ctrl u_port (
		.test_word_i(test_word),
		.global_csb_i(global_csb_i),
		.addr0_o(addr0_o),
		.din0_o(din0_o),
		.web0_o(web0_o),
		.wmask0_o(wmask0_o),
		.csb0_o(csb0_o),
		.addr1_o(addr1_o),
		.din1_o(din1_o),
		.web1_o(web1_o),
		.wmask1_o(wmask1_o),
		.csb1_o(csb1_o)
	);

endmodule

`default_nettype wire

/* source/openram_word_pkg.sv */
`default_nettype none

package openram_word_pkg;
	import openram_port_pkg::*;

	// command for one macro port, msb first
	typedef struct packed {
		sram_addr_t addr;
		sram_data_t din;   // write data, overwritten by capture
		logic csb;         // active low
		logic web;         // active low write enable
		sram_wmask_t wmask;
	} port_cmd_t;

	// full test word as the scan chain holds it
	typedef struct packed {
		chip_sel_t chip_select; // top bits, shifted out first
		port_cmd_t port0;
		port_cmd_t port1;       // bottom bits, nearest the scan input
	} test_word_fields_t;

	// the same word seen as a plain bit chain or as command fields
	typedef union packed {
		logic [$bits(test_word_fields_t)-1:0] raw;
		test_word_fields_t fields;
	} test_word_u;

	localparam int TEST_WORD_BITS = $bits(test_word_u);

endpackage

`default_nettype wire

/* source/sram_port_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_port_ctrl
	import openram_port_pkg::*, openram_word_pkg::*;
(
	input wire test_word_u test_word_i,
	input wire logic global_csb_i, // high blocks every macro

	// shared port 0 bus
	output sram_addr_t addr0_o,
	output sram_data_t din0_o,
	output logic web0_o,
	output sram_wmask_t wmask0_o,
	output csb_vec_t csb0_o,

	// shared port 1 bus
	output sram_addr_t addr1_o,
	output sram_data_t din1_o,
	output logic web1_o,
	output sram_wmask_t wmask1_o,
	output csb_vec_t csb1_o
);

	test_word_fields_t cmd;
	logic csb0_gated;
	logic csb1_gated;

	// puts one select value at the chosen macro, all other macros stay off
	function automatic csb_vec_t place_csb(input logic csb, input chip_sel_t sel);
		csb_vec_t vec;
		vec = '1;
		vec[sel] = csb;
		return vec;
	endfunction

	assign cmd = test_word_i.fields;

	// every macro sees the same address, data and write controls
	assign addr0_o = cmd.port0.addr;
	assign din0_o = cmd.port0.din;
	assign web0_o = cmd.port0.web;
	assign wmask0_o = cmd.port0.wmask;

	assign addr1_o = cmd.port1.addr;
	assign din1_o = cmd.port1.din;
	assign web1_o = cmd.port1.web;
	assign wmask1_o = cmd.port1.wmask;

	assign csb0_gated = global_csb_i | cmd.port0.csb;
	assign csb1_gated = global_csb_i | cmd.port1.csb;

	assign csb0_o = place_csb(csb0_gated, cmd.chip_select);
	assign csb1_o = place_csb(csb1_gated, cmd.chip_select);

	// never more than one macro enabled per port
	always_comb begin
		a_csb0_single: assert ($onehot0(~csb0_o))
			else $error("csb0_o enables more than one macro");
		a_csb1_single: assert ($onehot0(~csb1_o))
			else $error("csb1_o enables more than one macro");
	end

endmodule

`default_nettype wire

/* source/test_word_register.sv */
`timescale 1ns/1ps
`default_nettype none

`include "openram_config.svh"

module test_word_register
	import openram_port_pkg::*, openram_word_pkg::*;
(
	input wire logic clk,
	input wire logic resetn,

	// serial path from the gpio pin
	input wire logic gpio_i,
	input wire logic gpio_scan_i,
	input wire logic gpio_sram_load_i,

	// parallel path from the logic analyzer
	input wire logic la_in_load_i,
	input wire logic [TEST_WORD_BITS-1:0] la_data_i,
	input wire logic la_sram_load_i,

	// read data of every macro, both ports
	input wire sram_data_t sram_rdata0_i [`OPENRAM_MAX_CHIPS],
	input wire sram_data_t sram_rdata1_i [`OPENRAM_MAX_CHIPS],

	output test_word_u test_word_o,
	output logic [TEST_WORD_BITS-1:0] la_data_o,
	output logic gpio_o
);

	test_word_u word_q;
	test_word_u word_ctrl; // word with both din fields cleared
	sram_data_t rdata0_sel;
	sram_data_t rdata1_sel;
	logic capture;

	assign capture = gpio_sram_load_i | la_sram_load_i; // either trigger captures

	// the word's own select field picks the macro to read back
	assign rdata0_sel = sram_rdata0_i[word_q.fields.chip_select];
	assign rdata1_sel = sram_rdata1_i[word_q.fields.chip_select];

	// scan beats load, load beats capture
	always_ff @(posedge clk) begin
		if (!resetn) begin
			word_q <= '0;
		end else if (gpio_scan_i) begin
			word_q.raw <= {word_q.raw[TEST_WORD_BITS-2:0], gpio_i};
		end else if (la_in_load_i) begin
			word_q.raw <= la_data_i;
		end else if (capture) begin
			word_q.fields.port0.din <= rdata0_sel;
			word_q.fields.port1.din <= rdata1_sel;
		end
	end

	assign test_word_o = word_q;
	assign la_data_o = word_q.raw;
	assign gpio_o = word_q.raw[TEST_WORD_BITS-1]; // scan out from the top

	always_comb begin
		word_ctrl = word_q;
		word_ctrl.fields.port0.din = '0;
		word_ctrl.fields.port1.din = '0;
	end

	// a capture only touches the two data fields, the macro it reads from stays put
	property p_capture_keeps_control;
		@(posedge clk) disable iff (!resetn)
		(capture && !gpio_scan_i && !la_in_load_i) |=> (word_ctrl == $past(word_ctrl));
	endproperty

	a_capture_keeps_control: assert property (p_capture_keeps_control)
		else $error("capture changed bits outside the din fields");

endmodule

`default_nettype wire

/* src.f */
+incdir+include
source/openram_port_pkg.sv
source/openram_word_pkg.sv
source/test_word_register.sv
source/sram_port_ctrl.sv
source/openram_testchip.sv
verification/openram_checker.sv
verification/tb_openram_testchip.sv

/* verification/openram_cases.txt */
# columns: op, its arguments, then the expected test word in hex where the op has one
# load <word> <global_csb> | scan <count> <bits, leftmost first> | scan_load <bit> <word>
# load_capture <word> | capture_gpio | capture_la | check (expected word only)
check 0000000000000000000000000000
load 3a5a5a5a5a5a54c3c3c3c3c3c30f 0 3a5a5a5a5a5a54c3c3c3c3c3c30f
capture_gpio
load 90123456789ab3fedcba987654c1 0 90123456789ab3fedcba987654c1
capture_la
load f1111222233339444455556666d7 0 f1111222233339444455556666d7
capture_gpio
load 0abcdefabcdef21234123412348e 1 0abcdefabcdef21234123412348e
scan 8 10110100 bcdefabcdef21234123412348eb4
scan 4 0111 cdefabcdef21234123412348eb47
load 3a5a5a5a5a5a54c3c3c3c3c3c30f 0 3a5a5a5a5a5a54c3c3c3c3c3c30f
scan 4 1001 a5a5a5a5a5a54c3c3c3c3c3c30f9
scan 32 11011110101011011011111011101111 a5a54c3c3c3c3c3c30f9deadbeef
capture_la
load 0000000000000000000000000001 0 0000000000000000000000000001
scan 3 101 000000000000000000000000000d
scan_load 1 90123456789ab3fedcba987654c1 000000000000000000000000001b
load_capture f1111222233339444455556666d7 f1111222233339444455556666d7
capture_la
load 0123456789abc5def0123456789a 0 0123456789abc5def0123456789a
capture_gpio
load 0123456789abc5def0123456789a 1 0123456789abc5def0123456789a

/* verification/openram_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "openram_config.svh"

module openram_checker
	import openram_port_pkg::*;
#(
	parameter int WORD_BITS = `OPENRAM_SELECT_SIZE
		+ 2 * (`OPENRAM_ADDR_SIZE + `OPENRAM_DATA_SIZE + 2 + `OPENRAM_WMASK_SIZE)
)
(
	input wire logic clk,
	input wire logic resetn,

	// what the testbench drives into the DUT
	input wire logic gpio_in_i,
	input wire logic gpio_scan_i,
	input wire logic gpio_sram_load_i,
	input wire logic la_in_load_i,
	input wire logic [WORD_BITS-1:0] la_data_i,
	input wire logic la_sram_load_i,
	input wire logic global_csb_i,
	input wire sram_data_t sram_rdata0_i [`OPENRAM_MAX_CHIPS],
	input wire sram_data_t sram_rdata1_i [`OPENRAM_MAX_CHIPS],

	// what the DUT drives back
	input wire logic [WORD_BITS-1:0] la_word_i,
	input wire logic gpio_out_i,
	input wire sram_addr_t addr0_i,
	input wire sram_data_t din0_i,
	input wire logic web0_i,
	input wire sram_wmask_t wmask0_i,
	input wire csb_vec_t csb0_i,
	input wire sram_addr_t addr1_i,
	input wire sram_data_t din1_i,
	input wire logic web1_i,
	input wire sram_wmask_t wmask1_i,
	input wire csb_vec_t csb1_i,

	input wire logic file_check_i, // compare against the case file this cycle
	input wire logic [WORD_BITS-1:0] file_word_i,
	output int err_count_o,
	output int check_count_o,
	output int sample_count_o
);

	localparam int AW = `OPENRAM_ADDR_SIZE;
	localparam int DW = `OPENRAM_DATA_SIZE;
	localparam int MW = `OPENRAM_WMASK_SIZE;
	localparam int SW = `OPENRAM_SELECT_SIZE;
	localparam int PORT_BITS = AW + DW + 2 + MW; // addr, din, csb, web, wmask
	localparam int P0 = PORT_BITS; // port 1 sits at bit 0, port 0 right above it
	localparam int SEL_LSB = 2 * PORT_BITS;

	typedef logic [WORD_BITS-1:0] word_t;

	word_t model;
	logic started = 1'b0;
	int err_count = 0;
	int check_count = 0;
	int sample_count = 0;

	assign err_count_o = err_count;
	assign check_count_o = check_count;
	assign sample_count_o = sample_count;

	// ones everywhere, the port's select value at the chosen macro
	function automatic csb_vec_t expect_csb(input logic [SW-1:0] sel, input logic off);
		csb_vec_t vec;
		for (int k = 0; k < `OPENRAM_MAX_CHIPS; k++) begin
			vec[k] = (k == int'(sel)) ? off : 1'b1;
		end
		return vec;
	endfunction

	task automatic compare(input string name, input word_t expected, input word_t actual);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("error %s at %0t: expected %h, actual %h", name, $time, expected, actual);
		end
	endtask

	// reference word, scan first, then load, then capture
	always @(posedge clk) begin
		logic [SW-1:0] sel;
		sel = model[SEL_LSB +: SW];
		started <= 1'b1;
		if (!resetn) begin
			model <= '0;
		end else if (gpio_scan_i) begin
			model <= {model[WORD_BITS-2:0], gpio_in_i};
		end else if (la_in_load_i) begin
			model <= la_data_i;
		end else if (gpio_sram_load_i || la_sram_load_i) begin
			model[P0 + MW + 2 +: DW] <= sram_rdata0_i[sel];
			model[MW + 2 +: DW] <= sram_rdata1_i[sel];
		end
	end

	// outputs settle after the rising edge, so look at them half a cycle later
	always @(negedge clk) begin
		logic off0;
		logic off1;
		off0 = global_csb_i | model[P0 + MW + 1];
		off1 = global_csb_i | model[MW + 1];
		if (started) begin
			compare("la_data_o", model, la_word_i);
			compare("gpio_o", word_t'(model[WORD_BITS-1]), word_t'(gpio_out_i));
			compare("addr0_o", word_t'(model[P0 + MW + 2 + DW +: AW]), word_t'(addr0_i));
			compare("din0_o", word_t'(model[P0 + MW + 2 +: DW]), word_t'(din0_i));
			compare("web0_o", word_t'(model[P0 + MW]), word_t'(web0_i));
			compare("wmask0_o", word_t'(model[P0 +: MW]), word_t'(wmask0_i));
			compare("csb0_o", word_t'(expect_csb(model[SEL_LSB +: SW], off0)), word_t'(csb0_i));
			compare("addr1_o", word_t'(model[MW + 2 + DW +: AW]), word_t'(addr1_i));
			compare("din1_o", word_t'(model[MW + 2 +: DW]), word_t'(din1_i));
			compare("web1_o", word_t'(model[MW]), word_t'(web1_i));
			compare("wmask1_o", word_t'(model[0 +: MW]), word_t'(wmask1_i));
			compare("csb1_o", word_t'(expect_csb(model[SEL_LSB +: SW], off1)), word_t'(csb1_i));
			if (file_check_i) begin
				compare("la_data_o against case file", file_word_i, la_word_i);
			end
			sample_count++;
		end
	end

endmodule

`default_nettype wire

/* verification/tb_openram_testchip.sv */
`timescale 1ns/1ps
`default_nettype none

`include "openram_config.svh"

module tb_openram_testchip
	import openram_port_pkg::*, openram_word_pkg::*;
();

	localparam int SAMPLE_TIMEOUT = 16; // cycles

	logic clk;
	logic resetn;
	logic gpio_i;
	logic gpio_scan_i;
	logic gpio_sram_load_i;
	logic la_in_load_i;
	logic [TEST_WORD_BITS-1:0] la_data_i;
	logic la_sram_load_i;
	logic global_csb_i;
	sram_data_t rdata0 [`OPENRAM_MAX_CHIPS];
	sram_data_t rdata1 [`OPENRAM_MAX_CHIPS];

	logic [TEST_WORD_BITS-1:0] la_data_o;
	logic gpio_o;
	sram_addr_t addr0_o;
	sram_data_t din0_o;
	logic web0_o;
	sram_wmask_t wmask0_o;
	csb_vec_t csb0_o;
	sram_addr_t addr1_o;
	sram_data_t din1_o;
	logic web1_o;
	sram_wmask_t wmask1_o;
	csb_vec_t csb1_o;

	logic file_check;
	logic [TEST_WORD_BITS-1:0] file_word;
	int err_count;
	int check_count;
	int sample_count;
	int tb_failures;
	logic [31:0] lfsr;

	always #2 clk = ~clk;

	openram_testchip DUT (
		.clk(clk), .resetn(resetn),
		.gpio_i(gpio_i), .gpio_scan_i(gpio_scan_i), .gpio_sram_load_i(gpio_sram_load_i),
		.la_in_load_i(la_in_load_i), .la_data_i(la_data_i), .la_sram_load_i(la_sram_load_i),
		.global_csb_i(global_csb_i), .sram_rdata0_i(rdata0), .sram_rdata1_i(rdata1),
		.la_data_o(la_data_o), .gpio_o(gpio_o),
		.addr0_o(addr0_o), .din0_o(din0_o), .web0_o(web0_o), .wmask0_o(wmask0_o), .csb0_o(csb0_o),
		.addr1_o(addr1_o), .din1_o(din1_o), .web1_o(web1_o), .wmask1_o(wmask1_o), .csb1_o(csb1_o)
	);

	openram_checker u_checker (
		.clk(clk), .resetn(resetn),
		.gpio_in_i(gpio_i), .gpio_scan_i(gpio_scan_i), .gpio_sram_load_i(gpio_sram_load_i),
		.la_in_load_i(la_in_load_i), .la_data_i(la_data_i), .la_sram_load_i(la_sram_load_i),
		.global_csb_i(global_csb_i), .sram_rdata0_i(rdata0), .sram_rdata1_i(rdata1),
		.la_word_i(la_data_o), .gpio_out_i(gpio_o),
		.addr0_i(addr0_o), .din0_i(din0_o), .web0_i(web0_o), .wmask0_i(wmask0_o), .csb0_i(csb0_o),
		.addr1_i(addr1_o), .din1_i(din1_o), .web1_i(web1_o), .wmask1_i(wmask1_o), .csb1_i(csb1_o),
		.file_check_i(file_check), .file_word_i(file_word),
		.err_count_o(err_count), .check_count_o(check_count), .sample_count_o(sample_count)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	task automatic next_random_word(output sram_data_t word);
		for (int b = 0; b < `OPENRAM_DATA_SIZE; b++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			word[b] = lfsr[0];
		end
	endtask

	// hand the expected word to the checker and wait until it has sampled once
	task automatic end_operation(input logic has_word, input logic [TEST_WORD_BITS-1:0] word);
		int start;
		int waited;
		file_check <= has_word;
		file_word <= word;
		start = sample_count;
		waited = 0;
		while (sample_count == start && waited < SAMPLE_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		file_check <= 1'b0;
		if (sample_count == start) begin
			$display("timeout: the checker took no sample within %0d cycles", SAMPLE_TIMEOUT);
			tb_failures++;
		end
	endtask

	task automatic shift_bits_in(input int nbits, input logic [TEST_WORD_BITS-1:0] bits);
		for (int i = nbits - 1; i >= 0; i--) begin
			gpio_scan_i <= 1'b1;
			gpio_i <= bits[i]; // leftmost bit of the string goes first
			@(posedge clk);
		end
		gpio_scan_i <= 1'b0;
		gpio_i <= 1'b0;
	endtask

	task automatic run_case_line(input string line);
		string op;
		logic [TEST_WORD_BITS-1:0] word;
		logic [TEST_WORD_BITS-1:0] expected;
		int num;
		int fields;
		op = "";
		fields = $sscanf(line, "%s", op);
		if (fields < 1 || op.substr(0, 0) == "#") begin
			return;
		end
		if (op == "check") begin
			fields = $sscanf(line, "%s %h", op, expected) - 2;
			end_operation(1'b1, expected);
		end else if (op == "load") begin
			fields = $sscanf(line, "%s %h %d %h", op, word, num, expected) - 4;
			la_in_load_i <= 1'b1;
			la_data_i <= word;
			global_csb_i <= num[0];
			@(posedge clk);
			la_in_load_i <= 1'b0;
			end_operation(1'b1, expected);
		end else if (op == "scan") begin
			fields = $sscanf(line, "%s %d %b %h", op, num, word, expected) - 4;
			shift_bits_in(num, word);
			end_operation(1'b1, expected);
		end else if (op == "capture_gpio" || op == "capture_la") begin
			fields = 0;
			gpio_sram_load_i <= (op == "capture_gpio");
			la_sram_load_i <= (op == "capture_la");
			@(posedge clk);
			gpio_sram_load_i <= 1'b0;
			la_sram_load_i <= 1'b0;
			end_operation(1'b0, '0); // din fields come from the read data, checker knows them
		end else if (op == "scan_load") begin
			fields = $sscanf(line, "%s %d %h %h", op, num, word, expected) - 4;
			gpio_scan_i <= 1'b1;
			gpio_i <= num[0];
			la_in_load_i <= 1'b1;
			la_data_i <= word;
			@(posedge clk);
			gpio_scan_i <= 1'b0;
			la_in_load_i <= 1'b0;
			end_operation(1'b1, expected);
		end else if (op == "load_capture") begin
			fields = $sscanf(line, "%s %h %h", op, word, expected) - 3;
			la_in_load_i <= 1'b1;
			la_data_i <= word;
			la_sram_load_i <= 1'b1;
			@(posedge clk);
			la_in_load_i <= 1'b0;
			la_sram_load_i <= 1'b0;
			end_operation(1'b1, expected);
		end else begin
			fields = -1;
		end
		if (fields != 0) begin
			$display("case line not understood: %s", line);
			tb_failures++;
		end
	endtask

	initial begin
		int fd;
		string line;
		clk = 1'b0;
		resetn = 1'b0;
		gpio_i = 1'b0;
		gpio_scan_i = 1'b0;
		gpio_sram_load_i = 1'b0;
		la_in_load_i = 1'b0;
		la_data_i = '0;
		la_sram_load_i = 1'b0;
		global_csb_i = 1'b0;
		file_check = 1'b0;
		file_word = '0;
		tb_failures = 0;
		lfsr = 32'h8998_008b;
		for (int m = 0; m < `OPENRAM_MAX_CHIPS; m++) begin
			next_random_word(rdata0[m]);
			next_random_word(rdata1[m]);
		end
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		fd = $fopen("verification/openram_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file verification/openram_cases.txt");
			tb_failures++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0) begin
					run_case_line(line);
				end
			end
			$fclose(fd);
		end
		if (check_count == 0) begin
			$display("the checker made no comparisons");
			tb_failures++;
		end
		$display("checks %0d, value errors %0d, other failures %0d",
			check_count, err_count, tb_failures);
		if (err_count == 0 && tb_failures == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
